// File: design/fetch_pkg.sv
// fetch frontend shared definitions
// bus and parcel widths, the vector types built on them, the
// prefetch queue depth and the first fetch address after reset
package fetch_pkg;

	// --------------------------------------------------
	// widths

	// byte address width of the fetch bus
	localparam int W_ADDR = 32;
	// every fetch is one full bus word
	localparam int W_DATA = 32;
	// an instruction parcel is one halfword
	localparam int W_HALF = 16;

	// number of prefetch slots between the bus and the CIR
	// two is enough to keep fetching at full rate while decode stalls
	localparam int QUEUE_DEPTH = 2;

	// first fetch address after reset, must be word aligned
	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0000;

	// --------------------------------------------------
	// vector types

	typedef logic [W_ADDR-1:0] addr_t;
	typedef logic [W_DATA-1:0] word_t;
	typedef logic [W_HALF-1:0] half_t;

	// one bit per halfword of a bus word, bit 0 is the lower halfword
	typedef logic [1:0] hwmask_t;

	// halfword count, 0 to 2 at the decode interface
	// the assembler also uses it for its 0 to 3 buffer level
	typedef logic [1:0] hwcount_t;

	// number of bus fetches still waiting for their data
	typedef logic [1:0] pending_t;

endpackage

// File: design/fetch_requester.sv
// fetch request generator
// runs word-aligned fetches ahead of decode, redirects on jumps
// and qualifies bus responses before they enter the prefetch queue
`timescale 1ns/100ps

module fetch_requester (
	input  logic                              clk,
	input  logic                              rst_n,
	output fetch_pkg::addr_t                  mem_addr,
	output logic                              mem_addr_vld,
	input  logic                              mem_addr_rdy,
	input  fetch_pkg::word_t                  mem_data,
	input  logic                              mem_data_err,
	input  logic                              mem_data_vld,
	input  fetch_pkg::addr_t                  jump_target,
	input  logic                              jump_target_vld,
	output logic                              jump_target_rdy,
	input  logic [fetch_pkg::QUEUE_DEPTH-1:0] slot_valid,
	input  logic                              bypass_take,
	output logic                              push,
	output logic                              flush,
	output fetch_pkg::word_t                  bus_word,
	output logic                              bus_err,
	output fetch_pkg::hwmask_t                bus_hwmask
);

	// next word address to request, always word aligned
	fetch_pkg::addr_t    fetch_addr;
	// set while an address phase waits for mem_addr_rdy
	logic                mem_addr_hold;
	// keeps the bus quiet for the first cycle out of reset
	logic                reset_holdoff;
	fetch_pkg::pending_t pending;
	fetch_pkg::pending_t discard;
	// valid halfwords of the next response that will be kept
	fetch_pkg::hwmask_t  dph_hwmask;

	logic jump_now;
	logic addr_go;
	logic addr_issue;
	logic req_vld;
	logic queue_full;
	logic queue_almost_full;
	logic pending_full;
	logic fetch_stall;
	logic data_ok;

	// --------------------------------------------------
	// request generation

	// a held request must not move, so jumps wait until it is accepted
	assign jump_target_rdy = !mem_addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;
	assign flush           = jump_now;

	assign queue_full        = slot_valid[fetch_pkg::QUEUE_DEPTH-1];
	assign queue_almost_full = slot_valid[fetch_pkg::QUEUE_DEPTH-2];
	assign pending_full      = pending > 2'd1;

	// stall early enough that every response in flight still finds a slot
	// the registered pending count keeps mem_addr_rdy out of this path
	assign fetch_stall = queue_full || (queue_almost_full && pending != 2'd0) || pending_full;

	always_comb begin
		mem_addr = fetch_addr;
		req_vld  = 1'b0;
		if (mem_addr_hold) begin
			req_vld = 1'b1;
		end else if (jump_target_vld) begin
			// jump goes to the bus in the same cycle, the queue is flushed anyway
			mem_addr = {jump_target[fetch_pkg::W_ADDR-1:2], 2'b00};
			req_vld  = !pending_full;
		end else begin
			req_vld = !fetch_stall;
		end
	end

	assign mem_addr_vld = req_vld && !reset_holdoff;
	assign addr_go      = mem_addr_vld && mem_addr_rdy;
	// a request is counted once, in the first cycle it is shown
	assign addr_issue   = mem_addr_vld && !mem_addr_hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= fetch_pkg::RESET_VECTOR;
		end else if (jump_now) begin
			// skip ahead by one word if the jump request went straight through
			fetch_addr <= {jump_target[fetch_pkg::W_ADDR-1:2] +
				(fetch_pkg::W_ADDR-2)'(addr_go), 2'b00};
		end else if (addr_go) begin
			fetch_addr <= fetch_addr + fetch_pkg::addr_t'(4);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			mem_addr_hold <= 1'b0;
		end else begin
			reset_holdoff <= 1'b0;
			mem_addr_hold <= mem_addr_vld && !mem_addr_rdy;
		end
	end

	// --------------------------------------------------
	// bus tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 2'd0;
			discard <= 2'd0;
		end else begin
			pending <= pending + fetch_pkg::pending_t'(addr_issue)
				- fetch_pkg::pending_t'(mem_data_vld);
			// every fetch already issued before the jump belongs to the old path
			if (jump_now) begin
				discard <= pending - fetch_pkg::pending_t'(mem_data_vld);
			end else if (discard != 2'd0 && mem_data_vld) begin
				discard <= discard - 2'd1;
			end
		end
	end

	// responses come back in order, so the first kept one after a jump
	// is the word holding the jump target
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_hwmask <= 2'b11;
		end else if (jump_now) begin
			// odd halfword target drops the lower half of that word
			dph_hwmask <= {1'b1, !jump_target[1]};
		end else if (data_ok) begin
			dph_hwmask <= 2'b11;
		end
	end

	// --------------------------------------------------
	// response qualification

	assign data_ok    = mem_data_vld && discard == 2'd0;
	assign bus_word   = mem_data;
	assign bus_err    = mem_data_err;
	// zero mask marks a cycle with nothing usable on the bus
	assign bus_hwmask = data_ok ? dph_hwmask : 2'b00;
	// a word the CIR takes straight off the bus must not be queued as well
	assign push       = data_ok && !bypass_take;

endmodule

// File: design/prefetch_slot.sv
// prefetch queue entry
// holds one fetched word with its error bit and halfword mask,
// refills from the entry above and forwards unabsorbed pushes
`timescale 1ns/100ps

module prefetch_slot (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               pop,
	input  logic               push_in,
	output logic               push_up,
	input  fetch_pkg::word_t   refill_word,
	input  logic               refill_err,
	input  fetch_pkg::hwmask_t refill_hwmask,
	output fetch_pkg::word_t   pass_word,
	output logic               pass_err,
	output fetch_pkg::hwmask_t pass_hwmask,
	output logic               valid
);

	fetch_pkg::word_t   word_q;
	logic               err_q;
	fetch_pkg::hwmask_t hwmask_q;
	logic               load;

	// an entry with no valid halfword is empty
	assign valid = |hwmask_q;

	// on a pop every entry takes the contents of the one above,
	// the topmost valid entry takes the bus word through the chain
	assign load = pop || (push_in && !valid);

	// a push goes further up only when this entry is busy and nothing moves down
	assign push_up = push_in && valid && !pop;

	// an empty entry is transparent, which gives the queue bypass at slot 0
	assign pass_word   = valid ? word_q : refill_word;
	assign pass_err    = valid ? err_q : refill_err;
	assign pass_hwmask = valid ? hwmask_q : refill_hwmask;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hwmask_q <= 2'b00;
		end else if (flush) begin
			hwmask_q <= 2'b00;
		end else if (pop) begin
			// an empty entry stays empty on a pop so the bus word lands only once
			hwmask_q <= valid ? refill_hwmask : 2'b00;
		end else if (push_in && !valid) begin
			hwmask_q <= refill_hwmask;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			word_q <= refill_word;
			err_q  <= refill_err;
		end
	end

endmodule

// File: design/instr_assembler.sv
// instruction assembly
// aligns fetched halfwords into the CIR and a spare halfword buffer,
// shifts out what decode consumed and tracks bus errors per halfword
`timescale 1ns/100ps

module instr_assembler (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	input  fetch_pkg::word_t          fetch_word,
	input  logic                      fetch_err,
	input  fetch_pkg::hwmask_t        fetch_hwmask,
	input  logic                      head_valid,
	output logic                      pop,
	output logic                      bypass_take,
	output fetch_pkg::half_t [1:0]    cir,
	output fetch_pkg::hwcount_t       cir_vld,
	output logic [1:0]                cir_err,
	input  fetch_pkg::hwcount_t       cir_use
);

	// number of valid halfwords across {hwbuf, cir}, 0 to 3
	fetch_pkg::hwcount_t level;
	fetch_pkg::hwcount_t level_kept;
	fetch_pkg::hwcount_t level_next;
	fetch_pkg::hwcount_t fill;
	fetch_pkg::half_t    hwbuf;

	fetch_pkg::half_t [1:0] fresh;
	fetch_pkg::half_t [2:0] kept;
	fetch_pkg::half_t [2:0] data_next;

	// error bit per halfword, in the same order as {hwbuf, cir}
	logic [2:0] err_q;
	logic [2:0] err_kept;
	logic [2:0] err_next;

	logic fetch_vld;
	logic room;

	// --------------------------------------------------
	// fresh data

	// the queue head or the live bus word, zero mask when neither has data
	assign fetch_vld = |fetch_hwmask;

	// after an odd jump only the upper half is valid, move it down
	assign fresh[1] = fetch_word[fetch_pkg::W_HALF +: fetch_pkg::W_HALF];
	assign fresh[0] = fetch_hwmask[0] ? fetch_word[0 +: fetch_pkg::W_HALF] :
		fetch_word[fetch_pkg::W_HALF +: fetch_pkg::W_HALF];

	// --------------------------------------------------
	// consume and refill

	// shift the leftover halfwords down by what decode used
	// halfwords past the new level are never looked at, so they are just copies
	always_comb begin
		case (cir_use)
			2'd2: begin
				kept     = {hwbuf, cir[1], hwbuf};
				err_kept = err_q >> 2;
			end
			2'd1: begin
				kept     = {hwbuf, hwbuf, cir[1]};
				err_kept = err_q >> 1;
			end
			default: begin
				kept     = {hwbuf, cir[1], cir[0]};
				err_kept = err_q;
			end
		endcase
	end

	assign level_kept = level - cir_use;

	// a whole word fits below level 2, a single halfword fits at level 2
	assign room = level_kept <= (&fetch_hwmask ? 2'd1 : 2'd2);

	assign pop         = room && head_valid;
	assign bypass_take = room && !head_valid && fetch_vld;

	// lay the fresh halfwords on top of what is left
	always_comb begin
		if (!room) begin
			data_next = kept;
			err_next  = err_kept;
		end else if (level_kept == 2'd2) begin
			data_next = {fresh[0], kept[1], kept[0]};
			err_next  = {fetch_err, err_kept[1:0]};
		end else if (level_kept == 2'd1) begin
			data_next = {fresh[1], fresh[0], kept[0]};
			err_next  = {{2{fetch_err}}, err_kept[0]};
		end else begin
			data_next = {kept[2], fresh[1], fresh[0]};
			err_next  = {err_kept[2], {2{fetch_err}}};
		end
	end

	always_comb begin
		fill = 2'd0;
		if (room && fetch_vld) begin
			fill = &fetch_hwmask ? 2'd2 : 2'd1;
		end
	end

	// a taken jump empties the CIR, whatever decode used this cycle
	assign level_next = flush ? 2'd0 : level_kept + fill;

	// --------------------------------------------------
	// registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= 2'd0;
			cir_vld <= 2'd0;
			err_q   <= 3'b000;
		end else begin
			level   <= level_next;
			// decode only ever sees up to two halfwords
			cir_vld <= (level_next == 2'd3) ? 2'd2 : level_next;
			err_q   <= err_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = err_q[1:0];

endmodule

// File: design/fetch_frontend.sv
// instruction fetch frontend top level
// connects the fetch requester, the prefetch slot chain and the
// instruction assembler between the fetch bus and decode
`timescale 1ns/100ps

module fetch_frontend (
	input  logic                   clk,
	input  logic                   rst_n,
	output fetch_pkg::addr_t       mem_addr,
	output logic                   mem_addr_vld,
	input  logic                   mem_addr_rdy,
	input  fetch_pkg::word_t       mem_data,
	input  logic                   mem_data_err,
	input  logic                   mem_data_vld,
	input  fetch_pkg::addr_t       jump_target,
	input  logic                   jump_target_vld,
	output logic                   jump_target_rdy,
	output fetch_pkg::half_t [1:0] cir,
	output fetch_pkg::hwcount_t    cir_vld,
	output logic [1:0]             cir_err,
	input  fetch_pkg::hwcount_t    cir_use
);

	// --------------------------------------------------
	// slot chain wiring

	// entry i of each chain is the output of slot i, the top entry is the bus
	fetch_pkg::word_t   chain_word   [fetch_pkg::QUEUE_DEPTH:0];
	logic               chain_err    [fetch_pkg::QUEUE_DEPTH:0];
	fetch_pkg::hwmask_t chain_hwmask [fetch_pkg::QUEUE_DEPTH:0];

	// push token enters at slot 0 and climbs to the first free slot
	// a token leaving the top slot would be an overflow
	logic [fetch_pkg::QUEUE_DEPTH:0]   push_chain;
	logic [fetch_pkg::QUEUE_DEPTH-1:0] slot_valid;

	logic flush;
	logic pop;
	logic bypass_take;

	// --------------------------------------------------
	// blocks

	fetch_requester requester_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.slot_valid      (slot_valid),
		.bypass_take     (bypass_take),
		.push            (push_chain[0]),
		.flush           (flush),
		.bus_word        (chain_word[fetch_pkg::QUEUE_DEPTH]),
		.bus_err         (chain_err[fetch_pkg::QUEUE_DEPTH]),
		.bus_hwmask      (chain_hwmask[fetch_pkg::QUEUE_DEPTH])
	);

	for (genvar i = 0; i < fetch_pkg::QUEUE_DEPTH; i++) begin : slot_gen
		prefetch_slot slot_inst (
			.clk           (clk),
			.rst_n         (rst_n),
			.flush         (flush),
			.pop           (pop),
			.push_in       (push_chain[i]),
			.push_up       (push_chain[i+1]),
			.refill_word   (chain_word[i+1]),
			.refill_err    (chain_err[i+1]),
			.refill_hwmask (chain_hwmask[i+1]),
			.pass_word     (chain_word[i]),
			.pass_err      (chain_err[i]),
			.pass_hwmask   (chain_hwmask[i]),
			.valid         (slot_valid[i])
		);
	end

	// slot 0 shows the queue head, or the live bus word while the queue is empty
	instr_assembler assembler_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.fetch_word   (chain_word[0]),
		.fetch_err    (chain_err[0]),
		.fetch_hwmask (chain_hwmask[0]),
		.head_valid   (slot_valid[0]),
		.pop          (pop),
		.bypass_take  (bypass_take),
		.cir          (cir),
		.cir_vld      (cir_vld),
		.cir_err      (cir_err),
		.cir_use      (cir_use)
	);

endmodule

// File: dv/fetch_frontend_assertions.sv
// fetch frontend protocol checks
// bus request stability, sequential fetch addresses, prefetch queue
// overflow and decode interface limits
`timescale 1ns/100ps

module fetch_frontend_assertions (
	input logic                            clk,
	input logic                            rst_n,
	input fetch_pkg::addr_t                mem_addr,
	input logic                            mem_addr_vld,
	input logic                            mem_addr_rdy,
	input logic                            jump_target_vld,
	input logic                            jump_target_rdy,
	input logic [fetch_pkg::QUEUE_DEPTH:0] push_chain,
	input fetch_pkg::hwcount_t             cir_vld,
	input fetch_pkg::hwcount_t             cir_use
);

	// number of assertion failures so far
	int failures = 0;

	// --------------------------------------------------
	// fetch bus

	// a request that was not accepted stays on the bus unchanged
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_addr_vld && !mem_addr_rdy |=> mem_addr_vld && $stable(mem_addr))
		else begin
			$error("fetch request changed while it was held");
			failures++;
		end

	// back to back requests without a taken jump walk through memory word by word
	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_addr_vld && mem_addr_rdy) ##1 (mem_addr_vld && !(jump_target_vld && jump_target_rdy))
		|-> mem_addr == $past(mem_addr) + 32'd4)
		else begin
			$error("fetch address did not advance by one word");
			failures++;
		end

	// --------------------------------------------------
	// prefetch queue

	// a push token that leaves the top slot has no entry left to land in
	assert property (@(posedge clk) disable iff (!rst_n) !push_chain[fetch_pkg::QUEUE_DEPTH])
		else begin
			$error("fetched word arrived with every prefetch slot already full");
			failures++;
		end

	// --------------------------------------------------
	// decode interface

	assert property (@(posedge clk) disable iff (!rst_n) cir_vld <= 2'd2)
		else begin
			$error("cir_vld above two halfwords");
			failures++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld)
		else begin
			$error("decode consumed more halfwords than the CIR holds");
			failures++;
		end

endmodule

bind fetch_frontend fetch_frontend_assertions assertions_inst (.*);

// File: dv/fetch_frontend_tb.sv
// fetch frontend testbench
// memory and decode models driven from the test data file, with jumps,
// a decode stall window and a halfword-by-halfword stream check
`timescale 1ns/100ps

module fetch_frontend_tb;

	logic                   clk;
	logic                   rst_n;
	fetch_pkg::addr_t       mem_addr;
	logic                   mem_addr_vld;
	logic                   mem_addr_rdy;
	fetch_pkg::word_t       mem_data;
	logic                   mem_data_err;
	logic                   mem_data_vld;
	fetch_pkg::addr_t       jump_target;
	logic                   jump_target_vld;
	logic                   jump_target_rdy;
	fetch_pkg::half_t [1:0] cir;
	fetch_pkg::hwcount_t    cir_vld;
	logic [1:0]             cir_err;
	fetch_pkg::hwcount_t    cir_use;

	// memory image, jump script and expected stream, see the data file
	logic [31:0] tdata [0:255];
	logic [31:0] lfsr;
	int          errors;
	int          assert_failures;
	int          cycle;
	int          ptr;
	int          jump_idx;
	int          jump_count;
	int          limit;
	int          last_due;
	bit          jump_pending;
	bit          first_seen;
	bit          stall_seen;
	bit          stalling;
	bit          done;
	bit          timed_out;
	// requests accepted by the memory model, answered in order
	fetch_pkg::addr_t req_q [$];
	int               due_q [$];

	fetch_frontend fetch_frontend_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// 32-bit fibonacci LFSR, taps 32 22 2 1, one step per random bit
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// compare the halfwords of one consumed instruction with the stream
	task automatic consume_instruction(input int halves);
		for (int i = 0; i < halves; i++) begin
			check_value($sformatf("cir[%0d]", i), cir[i], {16'h0, tdata[ptr][15:0]});
			check_value($sformatf("cir_err[%0d]", i), cir_err[i], tdata[ptr][16]);
			ptr++;
		end
	endtask

	// --------------------------------------------------
	// stimulus and checking

	initial begin
		int base;
		int need;
		int idx;
		int due;
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = '0;
		mem_data_err    = 1'b0;
		mem_data_vld    = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_use         = 2'd0;
		lfsr            = 32'h7f04_30cc;
		errors          = 0;
		cycle           = 0;
		ptr             = 'h80;
		jump_idx        = 0;
		last_due        = 0;
		jump_pending    = 1'b0;
		first_seen      = 1'b0;
		stall_seen      = 1'b0;
		done            = 1'b0;
		timed_out       = 1'b0;
		$readmemh("dv/fetch_frontend_testdata.txt", tdata);
		jump_count = tdata['h40];
		// the last jump plus enough cycles to drain its whole segment
		limit = tdata['h43 + 3 * (jump_count - 1)] + 400;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		while (!done && !timed_out) begin
			@(negedge clk);
			cycle++;
			base = 'h43 + 3 * jump_idx;
			if (!jump_pending && jump_idx < jump_count && cycle >= tdata[base]) begin
				jump_pending = 1'b1;
			end
			jump_target_vld = jump_pending;
			jump_target     = jump_pending ? tdata[base + 1] : '0;
			mem_addr_rdy    = next_random_bit();
			// oldest request whose latency has run out goes on the bus
			mem_data_vld = 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				idx          = req_q[0][5:2];
				mem_data     = tdata[2 * idx + 1];
				mem_data_err = tdata[2 * idx][0];
				mem_data_vld = 1'b1;
				void'(req_q.pop_front());
				void'(due_q.pop_front());
			end
			// decode takes a whole instruction, never past the segment end
			cir_use  = 2'd0;
			stalling = cycle >= tdata['h41] && cycle < tdata['h41] + tdata['h42];
			if (!jump_pending && !stalling && cir_vld != 2'd0 && !tdata[ptr][20]) begin
				need = (cir[0][1:0] == 2'b11) ? 2 : 1;
				if (cir_vld >= need && next_random_bit()) begin
					cir_use = fetch_pkg::hwcount_t'(need);
					consume_instruction(need);
				end
			end
			// outputs settled, look at what the next rising edge will take
			#3;
			if (stalling && !mem_addr_vld) begin
				stall_seen = 1'b1;
			end
			if (mem_addr_vld && !first_seen) begin
				check_value("mem_addr", mem_addr, fetch_pkg::RESET_VECTOR);
				first_seen = 1'b1;
			end
			if (mem_addr_vld && mem_addr_rdy) begin
				due = cycle + 1 + next_random_bit();
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				req_q.push_back(mem_addr);
				due_q.push_back(due);
			end
			if (jump_target_vld && jump_target_rdy) begin
				// the script target rounded down to its word
				if (mem_addr_vld) begin
					check_value("mem_addr", mem_addr, tdata[base + 1] & 32'hffff_fffc);
				end
				ptr          = 'h80 + tdata[base + 2];
				jump_idx++;
				jump_pending = 1'b0;
			end
			done      = jump_idx == jump_count && tdata[ptr][20];
			timed_out = cycle >= limit;
		end
		if (timed_out) begin
			$display("timeout after %0d cycles, the expected stream was not consumed", cycle);
			errors++;
		end
		if (!stall_seen) begin
			$display("fetch requests never stopped while decode was stalled");
			errors++;
		end
		assert_failures = fetch_frontend_inst.assertions_inst.failures;
		$display("errors: %0d, assertion failures: %0d, cycles: %0d", errors,
			assert_failures, cycle);
		if (errors == 0 && assert_failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: fetch_frontend.f
design/fetch_pkg.sv
design/fetch_requester.sv
design/prefetch_slot.sv
design/instr_assembler.sv
design/fetch_frontend.sv
dv/fetch_frontend_assertions.sv
dv/fetch_frontend_tb.sv

// File: dv/fetch_frontend_testdata.txt
// @00 memory, per word: error flag, then the word (lower halfword first in the stream)
// @40 script: jump count, stall start, stall length, then per jump: cycle, target, stream offset
// @80 stream, per halfword: {error bit, halfword}, 100000 closes a segment
@00
0 00100093 0 01134505 0 80820020 0 12340537
0 05850505 0 00a52023 1 06134581 0 96020100
0 00000013 0 00010001 0 000106b7 0 00b38e3d
0 470100c5 0 00170793 1 46858c2e 0 00018082
@40
2 c 18
28 6 21
c8 20 3f
@80
00093 00010 04505 00113 00020 08082 00537 01234
00505 00585 02023 000a5 14581 10613 00100 09602
00013 00000 00001 00001 006b7 00001 08e3d 000b3
000c5 04701 00793 00017 18c2e 14685 08082 00001
100000
00113 00020 08082 00537 01234 00505 00585 02023
000a5 14581 10613 00100 09602 00013 00000 00001
00001 006b7 00001 08e3d 000b3 000c5 04701 00793
00017 18c2e 14685 08082 00001
100000
00013 00000 00001 00001 006b7 00001 08e3d 000b3
000c5 04701
100000
